//--- all.f
+incdir+.
psgPkg.sv
psgBusArb.sv
psgWaveChannel.sv
psgBusMux.sv
psgWaveSys.sv
psgWaveSys_sva.sv
psgWaveSys_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the wave fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module psgWaveSys_tb -f all.f -o simv; then
	echo "build failed"
	exit 1
fi

# keep running past assertion errors so the testbench can report them
if ! ./obj_dir/simv +verilator+error+limit+100000 > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
	exit 0
fi
exit 1

//--- psgWaveSys_tb.sv
`include "psg_defines.svh"

module psgWaveSys_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import psgPkg::*;

	// roughly twice the summed length of the six tests
	localparam int TIMEOUT_CYCLES = 4000;

	logic                     clk = 1'b0;
	logic                     rst = 1'b1;
	logic                     ce = 1'b0;
	psgChanCfg_t              cfg [`PSG_NUM_CH];
	logic [`PSG_NUM_CH-1:0]   tick = '0;
	logic [`PSG_SAMPLE_W-1:0] busDat = '0;
	logic                     busAck = 1'b0;
	logic                     busCyc;
	logic [`PSG_ADDR_W-1:0]   busAdr;
	logic [`PSG_SAMPLE_W-1:0] samples [`PSG_NUM_CH];
	logic [`PSG_NUM_CH-1:0]   sampleValid;
	logic [`PSG_NUM_CH-1:0]   sel;
	psgChanId_t               seln;

	// channels that ticked and still wait for their sample
	logic [`PSG_NUM_CH-1:0]   owed = '0;
	logic                     memBusy = 1'b0;
	int                       memWait = 0;
	int                       cycleCount = 0;
	int                       testsRun = 0;
	int                       testsBad = 0;
	int                       failMark = 0;

	psgWaveSys psgWaveSys_inst (
		.clk         (clk),
		.rst         (rst),
		.ce          (ce),
		.cfg         (cfg),
		.tick        (tick),
		.busDat      (busDat),
		.busAck      (busAck),
		.busCyc      (busCyc),
		.busAdr      (busAdr),
		.samples     (samples),
		.sampleValid (sampleValid),
		.sel         (sel),
		.seln        (seln)
	);

	initial begin
		forever #2 clk = ~clk;
	end

	// ========================================
	// memory model and monitors
	// ========================================

	// answers 1 to 4 cycles after busCyc rises
	always @(posedge clk) begin
		int delay;
		if (rst) begin
			busAck  <= 1'b0;
			memBusy <= 1'b0;
		end else begin
			busAck <= 1'b0;
			if (busCyc && !busAck) begin
				if (!memBusy) begin
					delay = $urandom % 4;
					if (delay == 0) begin
						busAck <= 1'b1;
						busDat <= busAdr[15:0] ^ 16'hA5C3;
					end else begin
						memBusy <= 1'b1;
						memWait <= delay - 1;
					end
				end else if (memWait == 0) begin
					busAck  <= 1'b1;
					busDat  <= busAdr[15:0] ^ 16'hA5C3;
					memBusy <= 1'b0;
				end else begin
					memWait <= memWait - 1;
				end
			end
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			owed <= '0;
		end else begin
			owed <= (owed & ~sampleValid) | tick;
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ========================================
	// stimulus
	// ========================================

	task automatic pulseTicks(input logic [`PSG_NUM_CH-1:0] mask);
		@(posedge clk);
		tick <= mask;
		@(posedge clk);
		tick <= '0;
	endtask

	// wait until every ticked channel has delivered while ce may toggle
	task automatic drainOwed(input bit randomCe);
		do begin
			@(posedge clk);
			if (randomCe) begin
				ce <= 1'($urandom);
			end
		end while (owed != '0);
		@(posedge clk);
		ce <= 1'b1;
	endtask

	task automatic endTest(input int num, input string name);
		int delta;
		delta = psgWaveSys_inst.svaInst.failCount - failMark;
		failMark = psgWaveSys_inst.svaInst.failCount;
		testsRun++;
		if (delta == 0) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			testsBad++;
			$display("test %0d %s: %0d assertion failures", num, name, delta);
		end
	endtask

	initial begin
		void'($urandom(46995));
		for (int i = 0; i < `PSG_NUM_CH; i++) begin
			cfg[i].base = 24'h100000 + 24'(i) * 24'h001010;
			cfg[i].len  = 12'(i + 2);
		end
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		ce  <= 1'b1;
		repeat (8) @(posedge clk);
		endTest(1, "reset state");

		pulseTicks(8'b0110_0100);
		drainOwed(1'b0);
		pulseTicks(8'b1000_1011);
		drainOwed(1'b0);
		endTest(2, "priority");

		// grants frozen while ce is low and then idle with no requests
		@(posedge clk);
		ce <= 1'b0;
		pulseTicks(8'b0001_0010);
		repeat (12) @(posedge clk);
		drainOwed(1'b1);
		repeat (8) @(posedge clk);
		endTest(3, "grant hold");

		pulseTicks('1);
		drainOwed(1'b1);
		endTest(4, "sample data");

		// channel 3 has six entries, so this wraps twice
		repeat (14) begin
			pulseTicks(8'b0000_1000);
			drainOwed(1'b0);
		end
		endTest(5, "index wrap");

		repeat (40) begin
			@(posedge clk);
			tick <= `PSG_NUM_CH'($urandom & $urandom & $urandom);
			ce   <= 1'($urandom);
		end
		@(posedge clk);
		tick <= '0;
		drainOwed(1'b1);
		endTest(6, "service");

		$display("tests run %0d, tests with errors %0d, assertion failures %0d",
			testsRun, testsBad, psgWaveSys_inst.svaInst.failCount);
		if (testsBad == 0 && psgWaveSys_inst.svaInst.failCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- psgWaveSys_sva.sv
`include "psg_defines.svh"

module psgWaveSys_sva (
	input logic                     clk,
	input logic                     rst,
	input logic                     ce,
	input logic                     arbAck,
	input logic [`PSG_NUM_CH-1:0]   reqVec,
	input logic [`PSG_NUM_CH-1:0]   tick,
	input psgPkg::psgChanCfg_t      cfg [`PSG_NUM_CH],
	input logic                     busCyc,
	input logic                     busAck,
	input logic [`PSG_ADDR_W-1:0]   busAdr,
	input logic [`PSG_SAMPLE_W-1:0] samples [`PSG_NUM_CH],
	input logic [`PSG_NUM_CH-1:0]   sampleValid,
	input logic [`PSG_NUM_CH-1:0]   sel,
	input psgPkg::psgChanId_t       seln
);
	timeunit 1ns;
	timeprecision 1ps;
	import psgPkg::*;

	logic                     seenTick;
	logic [`PSG_NUM_CH-1:0]   expSel;
	logic [LEN_W-1:0]         expIdx [`PSG_NUM_CH];
	logic                     ownerOk;
	logic                     dataBad;
	logic [`PSG_SAMPLE_W-1:0] dataGot;
	logic [`PSG_SAMPLE_W-1:0] dataExp;
	logic                     adrBad;
	logic [`PSG_ADDR_W-1:0]   adrExp;
	int                       failReset = 0;
	int                       failGrant = 0;
	int                       failData = 0;
	int                       failAdr = 0;
	int                       failBus = 0;
	int                       failCount;

	assign failCount = failReset + failGrant + failData + failAdr + failBus;

	// ========================================
	// expected grant and table index
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			seenTick <= 1'b0;
			expSel   <= '0;
			for (int i = 0; i < `PSG_NUM_CH; i++) begin
				expIdx[i] <= '0;
			end
		end else begin
			seenTick <= seenTick | (|tick);
			// isolate the lowest set request bit
			if (ce && arbAck && reqVec != '0) begin
				expSel <= reqVec & (~reqVec + `PSG_NUM_CH'(1));
			end
			for (int i = 0; i < `PSG_NUM_CH; i++) begin
				if (sampleValid[i]) begin
					expIdx[i] <= (expIdx[i] == cfg[i].len) ? '0 : expIdx[i] + LEN_W'(1);
				end
			end
		end
	end

	// seln has to name the granted channel
	assign ownerOk = (sel == '0) ? (seln == '0) : (sel == (`PSG_NUM_CH'(1) << seln));

	always_comb begin
		logic [`PSG_ADDR_W-1:0] chanAdr;
		dataBad = 1'b0;
		dataGot = '0;
		dataExp = '0;
		adrBad  = 1'b0;
		adrExp  = '0;
		for (int i = 0; i < `PSG_NUM_CH; i++) begin
			chanAdr = cfg[i].base + `PSG_ADDR_W'(expIdx[i]);
			// memory word is the low address half xor a fixed pattern
			if (sampleValid[i] && samples[i] != (chanAdr[15:0] ^ 16'hA5C3)) begin
				dataBad = 1'b1;
				dataGot = samples[i];
				dataExp = chanAdr[15:0] ^ 16'hA5C3;
			end
			if (busCyc && sel[i] && busAdr != chanAdr) begin
				adrBad = 1'b1;
				adrExp = chanAdr;
			end
		end
	end

	// ========================================
	// properties
	// ========================================

	resetQuiet: assert property (@(posedge clk) disable iff (rst)
		!seenTick |-> (sel == '0 && seln == '0 && !busCyc && sampleValid == '0))
		else begin
			failReset++;
			$error("FAIL sel=%h seln=%h busCyc=%h sampleValid=%h", sel, seln, busCyc,
				sampleValid);
		end

	grantMatch: assert property (@(posedge clk) disable iff (rst) sel == expSel && ownerOk)
		else begin
			failGrant++;
			$error("FAIL sel=%h seln=%h expected sel=%h", sel, seln, expSel);
		end

	// the owner keeps the bus until memory answers
	holdInCycle: assert property (@(posedge clk) disable iff (rst)
		busCyc && !busAck |=> $stable(sel) && $stable(seln))
		else begin
			failGrant++;
			$error("grant moved while a bus cycle still waited for its acknowledge");
		end

	dataMatch: assert property (@(posedge clk) disable iff (rst) !dataBad)
		else begin
			failData++;
			$error("FAIL samples=%h expected %h", dataGot, dataExp);
		end

	adrMatch: assert property (@(posedge clk) disable iff (rst) !adrBad)
		else begin
			failAdr++;
			$error("FAIL busAdr=%h expected %h", busAdr, adrExp);
		end

	ackInCycle: assert property (@(posedge clk) disable iff (rst) busAck |-> busCyc)
		else begin
			failBus++;
			$error("memory acknowledged while no bus cycle was open");
		end

endmodule

bind psgWaveSys psgWaveSys_sva svaInst (.*);

//--- psgWaveSys.sv
`include "psg_defines.svh"

module psgWaveSys (
	input  logic                     clk,
	input  logic                     rst,
	// arbiter clock enable
	input  logic                     ce,
	// per-channel table setup
	input  psgPkg::psgChanCfg_t      cfg [`PSG_NUM_CH],
	// per-channel sample rate pulses
	input  logic [`PSG_NUM_CH-1:0]   tick,
	// system bus
	input  logic [`PSG_SAMPLE_W-1:0] busDat,
	input  logic                     busAck,
	output logic                     busCyc,
	output logic [`PSG_ADDR_W-1:0]   busAdr,
	// fetched samples
	output logic [`PSG_SAMPLE_W-1:0] samples [`PSG_NUM_CH],
	output logic [`PSG_NUM_CH-1:0]   sampleValid,
	// current bus owner
	output logic [`PSG_NUM_CH-1:0]   sel,
	output psgPkg::psgChanId_t       seln
);
	import psgPkg::*;

	psgBusReq_t             busReqs [`PSG_NUM_CH];
	logic [`PSG_NUM_CH-1:0] reqVec;
	logic                   arbAck;

	// ========================================
	// wave channels
	// ========================================

	for (genvar i = 0; i < `PSG_NUM_CH; i++) begin : gChan
		psgWaveChannel chanInst (
			.clk         (clk),
			.rst         (rst),
			.cfg         (cfg[i]),
			.tick        (tick[i]),
			.sel         (sel[i]),
			.busAck      (busAck),
			.busDat      (busDat),
			.busReq      (busReqs[i]),
			.sample      (samples[i]),
			.sampleValid (sampleValid[i])
		);

		// request levels for the arbiter
		assign reqVec[i] = busReqs[i].req;
	end

	// ========================================
	// bus routing and arbitration
	// ========================================

	psgBusMux muxInst (
		.reqs   (busReqs),
		.sel    (sel),
		.seln   (seln),
		.busAck (busAck),
		.busCyc (busCyc),
		.busAdr (busAdr),
		.arbAck (arbAck)
	);

	psgBusArb arbInst (
		.clk  (clk),
		.rst  (rst),
		.ce   (ce),
		.ack  (arbAck),
		.req  (reqVec),
		.sel  (sel),
		.seln (seln)
	);

endmodule

//--- psgBusMux.sv
`include "psg_defines.svh"

module psgBusMux (
	// requests of all channels
	input  psgPkg::psgBusReq_t     reqs [`PSG_NUM_CH],
	// grant from the arbiter
	input  logic [`PSG_NUM_CH-1:0] sel,
	input  psgPkg::psgChanId_t     seln,
	input  logic                   busAck,
	// system bus read cycle
	output logic                   busCyc,
	output logic [`PSG_ADDR_W-1:0] busAdr,
	// update event for the arbiter
	output logic                   arbAck
);
	import psgPkg::*;

	psgBusReq_t owner;
	logic       ownerActive;

	// ========================================
	// owner routing
	// ========================================

	assign owner = reqs[seln];

	// the grant bit also has to be set, seln alone is zero after reset
	assign ownerActive = owner.req & sel[seln];

	assign busCyc = ownerActive;
	assign busAdr = owner.adr;

	// ========================================
	// arbiter update
	// ========================================

	// re-arbitrate on a finished transfer, or whenever the owner
	// has nothing to fetch (idle bus, or just out of reset)
	assign arbAck = busAck | ~ownerActive;

endmodule

//--- psgWaveChannel.sv
`include "psg_defines.svh"

module psgWaveChannel (
	input  logic                     clk,
	input  logic                     rst,
	// table base and length
	input  psgPkg::psgChanCfg_t      cfg,
	// sample rate pulse
	input  logic                     tick,
	// grant bit from the arbiter
	input  logic                     sel,
	input  logic                     busAck,
	input  logic [`PSG_SAMPLE_W-1:0] busDat,
	// read request toward the bus mux
	output psgPkg::psgBusReq_t       busReq,
	// last fetched sample word
	output logic [`PSG_SAMPLE_W-1:0] sample,
	// one-cycle pulse when sample is fresh
	output logic                     sampleValid
);
	import psgPkg::*;

	logic             pending;
	logic [LEN_W-1:0] idx;
	logic [LEN_W-1:0] idxNext;
	logic             done;

	// ========================================
	// read completion and index step
	// ========================================

	// our read is accepted when we own the bus and memory answers
	assign done = sel & pending & busAck;

	// wrap back to the table start after the last entry
	assign idxNext = (idx == cfg.len) ? '0 : idx + LEN_W'(1);

	// ========================================
	// request and index state
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			pending     <= 1'b0;
			idx         <= '0;
			sampleValid <= 1'b0;
		end else begin
			sampleValid <= done;
			if (done) begin
				pending <= 1'b0;
				idx     <= idxNext;
			end else if (tick) begin
				// a tick while still waiting is simply lost
				pending <= 1'b1;
			end
		end
	end

	// fetched word, loaded on the accepting ack
	always_ff @(posedge clk) begin
		if (done) begin
			sample <= busDat;
		end
	end

	// ========================================
	// request toward the bus
	// ========================================

	// address only moves when idx moves, so it is stable while pending
	always_comb begin
		busReq.req = pending;
		busReq.adr = cfg.base + `PSG_ADDR_W'(idx);
	end

endmodule

//--- psgBusArb.sv
`include "psg_defines.svh"

module psgBusArb (
	input  logic                   clk,
	input  logic                   rst,
	// clock enable, may run slower than clk
	input  logic                   ce,
	// transfer complete from the bus side
	input  logic                   ack,
	// one request level per channel
	input  logic [`PSG_NUM_CH-1:0] req,
	// one-hot grant, all zero until the first update
	output logic [`PSG_NUM_CH-1:0] sel,
	// index of the current owner
	output psgPkg::psgChanId_t     seln
);
	import psgPkg::*;

	psgChanId_t             winN;
	logic [`PSG_NUM_CH-1:0] winSel;
	logic                   anyReq;
	logic                   update;

	// ========================================
	// priority pick
	// ========================================

	// walk down from the top so the lowest requester is the last hit
	always_comb begin
		winN = '0;
		for (int i = `PSG_NUM_CH - 1; i >= 0; i--) begin
			if (req[i]) begin
				winN = psgChanId_t'(i);
			end
		end
		winSel = '0;
		winSel[winN] = 1'b1;
	end

	assign anyReq = |req;

	// owner moves only on an enabled transfer-complete
	// with nobody asking, the last owner stays
	assign update = ce & ack & anyReq;

	// ========================================
	// grant register
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			sel  <= '0;
			seln <= '0;
		end else if (update) begin
			sel  <= winSel;
			seln <= winN;
		end
	end

endmodule

//--- psgPkg.sv
`include "psg_defines.svh"

package psgPkg;

	// ========================================
	// channel configuration
	// ========================================

	// wave index width, sets the longest table
	localparam int LEN_W = 12;

	// static setup of one channel
	// len holds the table length minus one
	typedef struct packed {
		logic [`PSG_ADDR_W-1:0] base;
		logic [LEN_W-1:0]       len;
	} psgChanCfg_t;

	// ========================================
	// bus side
	// ========================================

	// one channel's pending read
	typedef struct packed {
		logic                   req;
		logic [`PSG_ADDR_W-1:0] adr;
	} psgBusReq_t;

	// index of the channel that owns the bus
	typedef logic [2:0] psgChanId_t;

endpackage

//--- psg_defines.svh
`ifndef PSG_DEFINES_SVH
`define PSG_DEFINES_SVH

// ========================================
// wave-table fetch sizing
// ========================================

// number of wave-table channels
// the arbiter has exactly eight request ports, so this stays at 8
`define PSG_NUM_CH 8

// system bus address width
`define PSG_ADDR_W 24

// sample word width, same as the bus read data
`define PSG_SAMPLE_W 16

`endif
